//--- files.f
+incdir+source
+incdir+tests
source/circle_pkg.sv
source/circle_ctrl.sv
source/screen_clear.sv
source/circle_octants.sv
source/circle_top.sv
tests/circle_tb.sv

//--- run.sh
#!/bin/sh
# build the circle testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -f files.f --top-module circle_tb -o circle_sim

# a fatal stop returns non-zero, the output search decides the result
out=$(./obj_dir/circle_sim || true)
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qxF "Simulation finished: PASS"; then
    exit 0
else
    exit 1
fi

//--- tests/circle_checks.svh
`ifndef CIRCLE_CHECKS_SVH
`define CIRCLE_CHECKS_SVH

// ----------------------------------------
// random numbers
// ----------------------------------------

// xorshift32, shifts 13 17 5
function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] v;
    v = s;
    v = v ^ (v << 13);
    v = v ^ (v >> 17);
    v = v ^ (v << 5);
    return v;
endfunction

// ----------------------------------------
// reference model of the outline
// ----------------------------------------

// one octant point, kept only when it lands on the screen
function automatic void mark_expected(input int px, input int py);
    if (px >= 0 && px < `CIRCLE_SCREEN_W && py >= 0 && py < `CIRCLE_SCREEN_H) begin
        if (!exp_map[px][py]) begin
            exp_map[px][py] = 1'b1;
            exp_count++;
        end
    end
endfunction

// integer midpoint circle, fills exp_map and exp_count
function automatic void build_expected(input circle_pkg::circle_req_t rq);
    int cx;
    int cy;
    int ox;
    int oy;
    int crit;
    foreach (exp_map[i, j]) begin
        exp_map[i][j] = 1'b0;
    end
    exp_count = 0;
    cx = int'(rq.centre_x);
    cy = int'(rq.centre_y);
    ox = int'(rq.radius);
    oy = 0;
    crit = 1 - ox;
    while (oy <= ox) begin
        mark_expected(cx + ox, cy + oy);
        mark_expected(cx + oy, cy + ox);
        mark_expected(cx - ox, cy + oy);
        mark_expected(cx - oy, cy + ox);
        mark_expected(cx - ox, cy - oy);
        mark_expected(cx - oy, cy - ox);
        mark_expected(cx + ox, cy - oy);
        mark_expected(cx + oy, cy - ox);
        oy++;
        if (crit <= 0) begin
            crit += 2 * oy + 1;
        end else begin
            ox--;
            crit += 2 * (oy - ox) + 1;
        end
    end
endfunction

// ----------------------------------------
// compare tasks
// ----------------------------------------
task automatic check_pixel(input string name, input circle_pkg::pixel_t expected,
                           input circle_pkg::pixel_t actual);
    if (actual !== expected) begin
        stop_with_failure($sformatf("FAIL %s: expected x=%0d y=%0d colour=%0d, %s",
                                    name, expected.x, expected.y, expected.colour,
                                    $sformatf("actual x=%0d y=%0d colour=%0d",
                                              actual.x, actual.y, actual.colour)));
    end
endtask

task automatic check_count(input string name, input int expected, input int actual);
    if (actual != expected) begin
        stop_with_failure($sformatf("FAIL %s: expected %0d, actual %0d",
                                    name, expected, actual));
    end
endtask

`endif

//--- tests/circle_tb.sv
`default_nettype none
`timescale 1ns/1ps

`include "circle_settings.svh"

module circle_tb;

    // each run is a full sweep, a worst case draw, then hold and gaps
    localparam int n_tests         = 12;
    localparam int cycles_per_run  = 19200 + 8 * 256 + 100;
    localparam int watchdog_cycles = n_tests * cycles_per_run + 1000;
    localparam int hold_cycles     = 20;
    localparam int screen_pixels   = `CIRCLE_SCREEN_W * `CIRCLE_SCREEN_H;

    logic                   clk;
    logic                   rst_n;
    logic                   start;
    logic [2:0]             colour;
    logic [`CIRCLE_X_W-1:0] centre_x;
    logic [`CIRCLE_Y_W-1:0] centre_y;
    logic [`CIRCLE_X_W-1:0] radius;
    logic                   done;
    logic [`CIRCLE_X_W-1:0] vga_x;
    logic [`CIRCLE_Y_W-1:0] vga_y;
    logic [2:0]             vga_colour;
    logic                   vga_plot;

    // expected outline and what the frame buffer received
    bit exp_map    [`CIRCLE_SCREEN_W][`CIRCLE_SCREEN_H];
    bit black_map  [`CIRCLE_SCREEN_W][`CIRCLE_SCREEN_H];
    bit colour_map [`CIRCLE_SCREEN_W][`CIRCLE_SCREEN_H];
    int exp_count    = 0;
    int black_total  = 0;
    int colour_count = 0;
    int checks_done  = 0;
    logic done_q     = 1'b0;
    logic [31:0] rng_state = 32'hfb593295;
    circle_pkg::circle_req_t cur_req;
    string cur_name = "reset";

    circle_top circle_top_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .start      (start),
        .colour     (colour),
        .centre_x   (centre_x),
        .centre_y   (centre_y),
        .radius     (radius),
        .done       (done),
        .vga_x      (vga_x),
        .vga_y      (vga_y),
        .vga_colour (vga_colour),
        .vga_plot   (vga_plot)
    );

    task automatic stop_with_failure(input string what);
        $display("%s", what);
        $display("Simulation finished: FAIL");
        $fatal(1, "stopped at the first error");
    endtask

    `include "circle_checks.svh"

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // ----------------------------------------
    // frame buffer stand-in
    // ----------------------------------------
    task automatic record_black();
        if (colour_count > 0) begin
            stop_with_failure({cur_name, ": black plot after the first coloured plot"});
        end
        if (black_map[vga_x][vga_y]) begin
            stop_with_failure($sformatf("%s: pixel %0d,%0d cleared twice",
                                        cur_name, vga_x, vga_y));
        end
        black_map[vga_x][vga_y] = 1'b1;
        black_total++;
    endtask

    task automatic record_colour();
        circle_pkg::pixel_t seen;
        circle_pkg::pixel_t want;
        seen.x      = vga_x;
        seen.y      = vga_y;
        seen.colour = vga_colour;
        want        = seen;
        want.colour = cur_req.colour;
        if (!exp_map[vga_x][vga_y]) begin
            stop_with_failure($sformatf("%s: pixel %0d,%0d is not on the circle",
                                        cur_name, vga_x, vga_y));
        end
        check_pixel({cur_name, " colour"}, want, seen);
        if (!colour_map[vga_x][vga_y]) begin
            colour_map[vga_x][vga_y] = 1'b1;
            colour_count++;
        end
    endtask

    // sample plots on the rising edge, compare on the first cycle of done
    always @(posedge clk) begin
        if (rst_n && vga_plot) begin
            if (vga_x >= `CIRCLE_SCREEN_W || vga_y >= `CIRCLE_SCREEN_H) begin
                stop_with_failure($sformatf("%s: plot outside the screen at %0d,%0d",
                                            cur_name, vga_x, vga_y));
            end else if (vga_colour == 3'd0) begin
                record_black();
            end else begin
                record_colour();
            end
        end
        if (rst_n && done && !done_q) begin
            check_count({cur_name, " black total"}, screen_pixels, black_total);
            check_count({cur_name, " coloured set size"}, exp_count, colour_count);
            checks_done++;
        end
        done_q = done;
    end

    // ----------------------------------------
    // stimulus
    // ----------------------------------------
    task automatic clear_records();
        foreach (black_map[i, j]) begin
            black_map[i][j]  = 1'b0;
            colour_map[i][j] = 1'b0;
        end
        black_total  = 0;
        colour_count = 0;
    endtask

    task automatic run_circle(input string name, input int cx, input int cy,
                              input int r, input int col);
        int seen_before;
        @(negedge clk);
        cur_name         = name;
        cur_req.centre_x = cx[`CIRCLE_X_W-1:0];
        cur_req.centre_y = cy[`CIRCLE_Y_W-1:0];
        cur_req.radius   = r[`CIRCLE_X_W-1:0];
        cur_req.colour   = col[2:0];
        build_expected(cur_req);
        clear_records();
        centre_x    = cur_req.centre_x;
        centre_y    = cur_req.centre_y;
        radius      = cur_req.radius;
        colour      = cur_req.colour;
        start       = 1'b1;
        seen_before = checks_done;
        while (checks_done == seen_before) begin
            @(negedge clk);
        end
        // done is a level while start stays high
        repeat (hold_cycles) begin
            @(negedge clk);
            check_count({name, " done held"}, 1, int'(done));
        end
        start = 1'b0;
        @(negedge clk);
        check_count({name, " done after start low"}, 0, int'(done));
    endtask

    task automatic run_random(input string name);
        int cx;
        int cy;
        int r;
        int col;
        rng_state = xorshift32(rng_state);
        cx        = int'(rng_state[7:0]);
        rng_state = xorshift32(rng_state);
        cy        = int'(rng_state[6:0]);
        rng_state = xorshift32(rng_state);
        r         = int'(rng_state[7:0]);
        rng_state = xorshift32(rng_state);
        // colour zero would look like the clear
        col       = 1 + int'(rng_state % 7);
        run_circle(name, cx, cy, r, col);
    endtask

    initial begin
        rst_n    = 1'b0;
        start    = 1'b0;
        colour   = 3'd0;
        centre_x = '0;
        centre_y = '0;
        radius   = '0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        // quiet until the first start
        repeat (5) begin
            @(negedge clk);
            check_count("reset done", 0, int'(done));
            check_count("reset plot", 0, int'(vga_plot));
        end
        run_circle("centred radius 1", 80, 60, 1, 3);
        run_circle("centred radius 10", 80, 60, 10, 5);
        run_circle("centred radius 50", 80, 60, 50, 7);
        run_circle("radius 0", 80, 60, 0, 2);
        run_circle("left edge", 0, 60, 30, 4);
        run_circle("corner", 159, 119, 40, 6);
        run_circle("far corner radius 255", 255, 127, 255, 1);
        run_circle("centred radius 255", 80, 60, 255, 7);
        run_circle("off screen radius 200", 255, 127, 200, 3);
        run_circle("off screen small", 255, 127, 5, 5);
        run_random("random 1");
        run_random("random 2");
        $display("Simulation finished: PASS");
        $finish;
    end

    // ----------------------------------------
    // watchdog
    // ----------------------------------------
    initial begin
        repeat (watchdog_cycles) @(posedge clk);
        $display("timeout: done never rose within %0d cycles", watchdog_cycles);
        $display("Simulation finished: FAIL");
        $fatal(1, "watchdog expired");
    end

endmodule

`default_nettype wire

//--- source/circle_top.sv
`default_nettype none
`timescale 1ns/1ps

`include "circle_settings.svh"

module circle_top (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    start,
    input  logic [2:0]              colour,
    input  logic [`CIRCLE_X_W-1:0]  centre_x,
    input  logic [`CIRCLE_Y_W-1:0]  centre_y,
    input  logic [`CIRCLE_X_W-1:0]  radius,
    output logic                    done,
    output logic [`CIRCLE_X_W-1:0]  vga_x,
    output logic [`CIRCLE_Y_W-1:0]  vga_y,
    output logic [2:0]              vga_colour,
    output logic                    vga_plot
);

    circle_pkg::circle_req_t  req;
    circle_pkg::ctrl_state_e  state;
    logic                     clear_go;
    logic                     clear_end;
    logic                     draw_go;
    logic                     draw_end;

    circle_pkg::pixel_t       clear_pix;
    circle_pkg::pixel_t       draw_pix;
    circle_pkg::pixel_t       out_pix;
    logic                     clear_plot;
    logic                     draw_plot;

    // ----------------------------------------
    // phase controller
    // ----------------------------------------
    circle_ctrl circle_ctrl_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .start     (start),
        .colour    (colour),
        .centre_x  (centre_x),
        .centre_y  (centre_y),
        .radius    (radius),
        .clear_end (clear_end),
        .draw_end  (draw_end),
        .req       (req),
        .state     (state),
        .clear_go  (clear_go),
        .draw_go   (draw_go),
        .done      (done)
    );

    // black sweep of the whole frame
    screen_clear screen_clear_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .clear_go  (clear_go),
        .pix       (clear_pix),
        .plot      (clear_plot),
        .clear_end (clear_end)
    );

    // outline points, already clipped
    circle_octants circle_octants_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .draw_go  (draw_go),
        .req      (req),
        .pix      (draw_pix),
        .plot     (draw_plot),
        .draw_end (draw_end)
    );

    // ----------------------------------------
    // vga port selection
    // ----------------------------------------
    assign out_pix = (state == circle_pkg::state_clear) ? clear_pix : draw_pix;

    assign vga_x      = out_pix.x;
    assign vga_y      = out_pix.y;
    assign vga_colour = out_pix.colour;
    // the two engines never plot in the same cycle
    assign vga_plot   = clear_plot | draw_plot;

endmodule

`default_nettype wire

//--- source/circle_octants.sv
`default_nettype none
`timescale 1ns/1ps

`include "circle_settings.svh"

module circle_octants (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     draw_go,
    input  circle_pkg::circle_req_t  req,
    output circle_pkg::pixel_t       pix,
    output logic                     plot,
    output logic                     draw_end
);

    // signed width for centre plus or minus offset, covers -255..510
    localparam int sum_w  = 10;
    // criterion needs a little more headroom than the offsets
    localparam int crit_w = sum_w + 2;

    localparam logic signed [sum_w-1:0] x_limit = sum_w'(`CIRCLE_SCREEN_W);
    localparam logic signed [sum_w-1:0] y_limit = sum_w'(`CIRCLE_SCREEN_H);

    logic                      active;
    logic [2:0]                oct;
    logic signed [sum_w-1:0]   offset_x;
    logic signed [sum_w-1:0]   offset_y;
    logic signed [crit_w-1:0]  crit;

    logic signed [sum_w-1:0]   next_x;
    logic signed [sum_w-1:0]   next_y;
    logic signed [crit_w-1:0]  next_crit;

    logic signed [sum_w-1:0]   cx_s;
    logic signed [sum_w-1:0]   cy_s;
    logic signed [sum_w-1:0]   sum_x;
    logic signed [sum_w-1:0]   sum_y;
    logic                      in_screen;

    // centre zero-extended into the signed sum width
    assign cx_s = sum_w'(req.centre_x);
    assign cy_s = sum_w'(req.centre_y);

    // ----------------------------------------
    // midpoint step
    // ----------------------------------------
    always_comb begin
        next_y = offset_y + 1;
        if (crit <= 0) begin
            // stay on this column
            next_x    = offset_x;
            next_crit = crit + crit_w'(2 * next_y + 1);
        end else begin
            // move one column inwards
            next_x    = offset_x - 1;
            next_crit = crit + crit_w'(2 * (next_y - next_x) + 1);
        end
    end

    // ----------------------------------------
    // octant point selection
    // ----------------------------------------
    always_comb begin
        case (oct)
            3'd0: begin
                sum_x = cx_s + offset_x;
                sum_y = cy_s + offset_y;
            end
            3'd1: begin
                sum_x = cx_s + offset_y;
                sum_y = cy_s + offset_x;
            end
            3'd2: begin
                sum_x = cx_s - offset_x;
                sum_y = cy_s + offset_y;
            end
            3'd3: begin
                sum_x = cx_s - offset_y;
                sum_y = cy_s + offset_x;
            end
            3'd4: begin
                sum_x = cx_s - offset_x;
                sum_y = cy_s - offset_y;
            end
            3'd5: begin
                sum_x = cx_s - offset_y;
                sum_y = cy_s - offset_x;
            end
            3'd6: begin
                sum_x = cx_s + offset_x;
                sum_y = cy_s - offset_y;
            end
            default: begin
                sum_x = cx_s + offset_y;
                sum_y = cy_s - offset_x;
            end
        endcase
    end

    // clip against the visible frame, negatives fail the lower bound
    assign in_screen = (sum_x >= 0) && (sum_x < x_limit) &&
                       (sum_y >= 0) && (sum_y < y_limit);

    always_comb begin
        pix.x      = sum_x[`CIRCLE_X_W-1:0];
        pix.y      = sum_y[`CIRCLE_Y_W-1:0];
        pix.colour = req.colour;
    end

    // clipped points still spend their cycle
    assign plot = active && in_screen;

    // ----------------------------------------
    // sequencing
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            active   <= 1'b0;
            oct      <= 3'd0;
            draw_end <= 1'b0;
        end else begin
            draw_end <= 1'b0;
            if (draw_go) begin
                active <= 1'b1;
                oct    <= 3'd0;
            end else if (active) begin
                oct <= oct + 3'd1;
                // loop ends once offset_y passes offset_x
                if (oct == 3'd7 && next_y > next_x) begin
                    active   <= 1'b0;
                    draw_end <= 1'b1;
                end
            end
        end
    end

    // offsets and criterion advance after the eighth octant
    always_ff @(posedge clk) begin
        if (draw_go) begin
            offset_x <= sum_w'(req.radius);
            offset_y <= '0;
            crit     <= crit_w'(1 - int'(req.radius));
        end else if (active && oct == 3'd7) begin
            offset_x <= next_x;
            offset_y <= next_y;
            crit     <= next_crit;
        end
    end

endmodule

`default_nettype wire

//--- source/screen_clear.sv
`default_nettype none
`timescale 1ns/1ps

`include "circle_settings.svh"

module screen_clear (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                clear_go,
    output circle_pkg::pixel_t  pix,
    output logic                plot,
    output logic                clear_end
);

    logic                   active;
    logic [`CIRCLE_X_W-1:0] x_cnt;
    logic [`CIRCLE_Y_W-1:0] y_cnt;
    logic                   last_x;
    logic                   last_y;

    // raster edges
    assign last_x = (x_cnt == `CIRCLE_X_W'(`CIRCLE_SCREEN_W - 1));
    assign last_y = (y_cnt == `CIRCLE_Y_W'(`CIRCLE_SCREEN_H - 1));

    // ----------------------------------------
    // raster counters, x fastest then y
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            active <= 1'b0;
            x_cnt  <= '0;
            y_cnt  <= '0;
        end else if (clear_go) begin
            active <= 1'b1;
            x_cnt  <= '0;
            y_cnt  <= '0;
        end else if (active) begin
            if (last_x) begin
                x_cnt <= '0;
                if (last_y) begin
                    // bottom right corner was the final pixel
                    active <= 1'b0;
                    y_cnt  <= '0;
                end else begin
                    y_cnt <= y_cnt + 1'b1;
                end
            end else begin
                x_cnt <= x_cnt + 1'b1;
            end
        end
    end

    // one black plot per cycle of the sweep
    always_comb begin
        pix.x      = x_cnt;
        pix.y      = y_cnt;
        pix.colour = 3'd0;
    end

    assign plot      = active;
    assign clear_end = active && last_x && last_y;

endmodule

`default_nettype wire

//--- source/circle_ctrl.sv
`default_nettype none
`timescale 1ns/1ps

`include "circle_settings.svh"

module circle_ctrl (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     start,
    input  logic [2:0]               colour,
    input  logic [`CIRCLE_X_W-1:0]   centre_x,
    input  logic [`CIRCLE_Y_W-1:0]   centre_y,
    input  logic [`CIRCLE_X_W-1:0]   radius,
    input  logic                     clear_end,
    input  logic                     draw_end,
    output circle_pkg::circle_req_t  req,
    output circle_pkg::ctrl_state_e  state,
    output logic                     clear_go,
    output logic                     draw_go,
    output logic                     done
);

    // ----------------------------------------
    // phase sequencing
    // ----------------------------------------

    // go strobes are registered one-cycle pulses
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state    <= circle_pkg::state_idle;
            clear_go <= 1'b0;
            draw_go  <= 1'b0;
        end else begin
            // default low, raised only on a phase change
            clear_go <= 1'b0;
            draw_go  <= 1'b0;
            case (state)
                circle_pkg::state_idle: begin
                    // start is only honoured from idle
                    if (start) begin
                        state    <= circle_pkg::state_clear;
                        clear_go <= 1'b1;
                    end
                end
                circle_pkg::state_clear: begin
                    // sweep finished, launch the octant stepper
                    if (clear_end) begin
                        state   <= circle_pkg::state_draw;
                        draw_go <= 1'b1;
                    end
                end
                circle_pkg::state_draw: begin
                    if (draw_end) begin
                        state <= circle_pkg::state_done;
                    end
                end
                circle_pkg::state_done: begin
                    // hold done as long as start is held
                    if (!start) begin
                        state <= circle_pkg::state_idle;
                    end
                end
                default: begin
                    state <= circle_pkg::state_idle;
                end
            endcase
        end
    end

    // ----------------------------------------
    // request capture
    // ----------------------------------------

    // inputs may change freely once the run has begun
    always_ff @(posedge clk) begin
        if (state == circle_pkg::state_idle && start) begin
            req.centre_x <= centre_x;
            req.centre_y <= centre_y;
            req.radius   <= radius;
            req.colour   <= colour;
        end
    end

    // level done straight from the state register
    assign done = (state == circle_pkg::state_done);

endmodule

`default_nettype wire

//--- source/circle_pkg.sv
`default_nettype none

`include "circle_settings.svh"

package circle_pkg;

    // ----------------------------------------
    // pixel as seen by the frame buffer
    // ----------------------------------------
    typedef struct packed {
        logic [`CIRCLE_X_W-1:0] x;
        logic [`CIRCLE_Y_W-1:0] y;
        logic [2:0]             colour;
    } pixel_t;

    // ----------------------------------------
    // drawing request, captured on start
    // ----------------------------------------
    typedef struct packed {
        logic [`CIRCLE_X_W-1:0] centre_x;
        logic [`CIRCLE_Y_W-1:0] centre_y;
        // radius uses the x width, up to 255
        logic [`CIRCLE_X_W-1:0] radius;
        logic [2:0]             colour;
    } circle_req_t;

    // ----------------------------------------
    // phase controller states
    // ----------------------------------------
    typedef enum logic [1:0] {
        state_idle,
        state_clear,
        state_draw,
        state_done
    } ctrl_state_e;

endpackage

`default_nettype wire

//--- source/circle_settings.svh
`ifndef CIRCLE_SETTINGS_SVH
`define CIRCLE_SETTINGS_SVH

// ----------------------------------------
// frame buffer geometry
// ----------------------------------------

// visible pixels per line
`define CIRCLE_SCREEN_W 160

// visible lines per frame
`define CIRCLE_SCREEN_H 120

// ----------------------------------------
// coordinate widths on the vga ports
// ----------------------------------------

// x spans 0..255 so radius shares this width
`define CIRCLE_X_W 8
`define CIRCLE_Y_W 7

`endif
